//--- verilog/lsu_op_pkg.sv
`default_nettype none

// core-side view of the load/store unit
package lsu_op_pkg;

    // encoding follows funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        LSU_LB  = 4'h0,
        LSU_LH  = 4'h1,
        LSU_LW  = 4'h2,
        LSU_LBU = 4'h4,
        LSU_LHU = 4'h5,
        LSU_SB  = 4'h8,
        LSU_SH  = 4'h9,
        LSU_SW  = 4'ha
    } lsu_op_e;

    // one memory instruction from the core
    typedef struct packed {
        lsu_op_e     op;
        // effective byte address
        logic [31:0] addr;
        // store data, low bits used for sb/sh
        logic [31:0] wdata;
    } lsu_req_t;

    // one response per request
    typedef struct packed {
        // extended load data, zero for stores and errors
        logic [31:0] ldata;
        // misaligned access, memory untouched
        logic        err;
    } lsu_rsp_t;

    // stores write memory, everything else reads
    function automatic logic is_store(input lsu_op_e op);
        return op inside {LSU_SB, LSU_SH, LSU_SW};
    endfunction

    // legal load encodings only
    function automatic logic is_load(input lsu_op_e op);
        return op inside {LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW};
    endfunction

endpackage

`default_nettype wire

//--- verilog/mem_bus_pkg.sv
`default_nettype none

// memory-side view, between the controller and the sram
package mem_bus_pkg;

    // one access per valid cycle, no ready
    typedef struct packed {
        // byte address with the low two bits cleared
        logic [31:0] addr;
        // data already moved into its byte lanes
        logic [31:0] wdata;
        // one bit per byte lane
        logic [3:0]  strb;
        // write enable, reads otherwise
        logic        we;
    } mem_req_t;

    // returned one cycle after the request
    typedef struct packed {
        // old word on writes
        logic [31:0] rdata;
    } mem_rsp_t;

    // same 32-bit word seen as lanes of different size
    typedef union packed {
        // bytes[0] is bits 7:0
        logic [3:0][7:0]  bytes;
        // halves[1] is bits 31:16
        logic [1:0][15:0] halves;
        // whole word
        logic [31:0]      word;
    } mem_word_u;

endpackage

`default_nettype wire

//--- verilog/lsu_store_align.sv
`default_nettype none

// moves store data into its byte lanes and builds the strobe
module lsu_store_align (
    input  lsu_op_pkg::lsu_op_e op,
    input  logic [1:0]          byte_off,
    input  logic [31:0]         wdata,
    output logic [31:0]         lane_data,
    output logic [3:0]          strb
);

    always_comb begin
        case (op)
            lsu_op_pkg::LSU_SB: begin
                // byte copied to every lane, strobe picks one
                lane_data = {4{wdata[7:0]}};
                strb      = 4'b0001 << byte_off;
            end
            lsu_op_pkg::LSU_SH: begin
                // halfword copied to both halves
                lane_data = {2{wdata[15:0]}};
                // only offset bit 1 matters once aligned
                strb      = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            lsu_op_pkg::LSU_SW: begin
                lane_data = wdata;
                strb      = 4'b1111;
            end
            default: begin
                // loads write nothing
                lane_data = 32'h0;
                strb      = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/lsu_load_extract.sv
`default_nettype none

// picks the addressed lanes out of the read word and extends them
module lsu_load_extract (
    input  lsu_op_pkg::lsu_op_e    op,
    input  logic [1:0]             byte_off,
    input  mem_bus_pkg::mem_word_u rword,
    // result is taken by the controller this cycle
    input  logic                   use_en,
    output logic [31:0]            ldata
);

    // selected byte and halfword
    logic [7:0]  sel_b;
    logic [15:0] sel_h;

    // byte view indexed by full offset
    assign sel_b = rword.bytes[byte_off];
    // halfword view indexed by offset bit 1
    assign sel_h = rword.halves[byte_off[1]];

    always_comb begin
        case (op)
            lsu_op_pkg::LSU_LB: begin
                ldata = {{24{sel_b[7]}}, sel_b};
            end
            lsu_op_pkg::LSU_LBU: begin
                ldata = {24'h0, sel_b};
            end
            lsu_op_pkg::LSU_LH: begin
                ldata = {{16{sel_h[15]}}, sel_h};
            end
            lsu_op_pkg::LSU_LHU: begin
                ldata = {16'h0, sel_h};
            end
            lsu_op_pkg::LSU_LW: begin
                ldata = rword.word;
            end
            default: begin
                // stores and illegal codes give zero
                ldata = 32'h0;
            end
        endcase
    end

    // the controller only consumes data for legal loads
    // use_en is a registered pulse, op is held well before it
    a_use_is_load: assert property (
        @(posedge use_en) lsu_op_pkg::is_load(op)
    ) else $error("load data used for non-load op %0h", op);

endmodule

`default_nettype wire

//--- verilog/lsu_ctrl.sv
`default_nettype none

// request handshake, alignment check, memory issue and held response
module lsu_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    // core request channel
    input  logic                  req_valid,
    output logic                  req_ready,
    input  lsu_op_pkg::lsu_req_t  req,
    // core response channel
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output lsu_op_pkg::lsu_rsp_t  rsp,
    // sram side
    output logic                  mem_req_valid,
    output mem_bus_pkg::mem_req_t mem_req,
    input  logic                  mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM,
        ST_RSP
    } state_e;

    state_e                 state;
    // accepted request, held until the response leaves
    lsu_op_pkg::lsu_req_t   req_q;
    // sram word registered before extraction
    mem_bus_pkg::mem_word_u rword_q;
    logic                   rword_vld;
    logic                   misalign;
    logic                   req_fire;
    logic                   rsp_fire;
    logic                   ld_use;
    logic [31:0]            lane_data;
    logic [3:0]             strb;
    logic [31:0]            ldata;

    // natural alignment on the incoming request
    always_comb begin
        case (req.op)
            lsu_op_pkg::LSU_LH,
            lsu_op_pkg::LSU_LHU,
            lsu_op_pkg::LSU_SH: misalign = req.addr[0];
            lsu_op_pkg::LSU_LW,
            lsu_op_pkg::LSU_SW: misalign = |req.addr[1:0];
            default:            misalign = 1'b0;
        endcase
    end

    // one request in flight at a time
    assign req_ready = (state == ST_IDLE);
    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;

    lsu_store_align u_store_align (
        .op        (req_q.op),
        .byte_off  (req_q.addr[1:0]),
        .wdata     (req_q.wdata),
        .lane_data (lane_data),
        .strb      (strb)
    );

    // word address, lanes and strobe all from the held request
    assign mem_req = '{
        addr:  {req_q.addr[31:2], 2'b00},
        wdata: lane_data,
        strb:  strb,
        we:    lsu_op_pkg::is_store(req_q.op)
    };

    // extractor result taken only for loads
    assign ld_use = rword_vld && !lsu_op_pkg::is_store(req_q.op);

    lsu_load_extract u_load_extract (
        .op       (req_q.op),
        .byte_off (req_q.addr[1:0]),
        .rword    (rword_q),
        .use_en   (ld_use),
        .ldata    (ldata)
    );

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            mem_req_valid <= 1'b0;
            rword_vld     <= 1'b0;
            rsp_valid     <= 1'b0;
        end else begin
            // single-cycle pulses
            mem_req_valid <= 1'b0;
            rword_vld     <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_fire) begin
                        if (misalign) begin
                            // error goes straight out, sram never sees it
                            state     <= ST_RSP;
                            rsp_valid <= 1'b1;
                        end else begin
                            state         <= ST_MEM;
                            mem_req_valid <= 1'b1;
                        end
                    end
                end
                ST_MEM: begin
                    if (mem_rsp_valid) begin
                        rword_vld <= 1'b1;
                    end
                    if (rword_vld) begin
                        state     <= ST_RSP;
                        rsp_valid <= 1'b1;
                    end
                end
                ST_RSP: begin
                    if (rsp_fire) begin
                        state     <= ST_IDLE;
                        rsp_valid <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= req;
            if (misalign) begin
                rsp <= '{ldata: 32'h0, err: 1'b1};
            end
        end
        if (mem_rsp_valid) begin
            rword_q <= mem_rsp.rdata;
        end
        // stores answer with zero data
        if (state == ST_MEM && rword_vld) begin
            rsp <= '{ldata: ld_use ? ldata : 32'h0, err: 1'b0};
        end
    end

    // request side stays closed while a response waits
    a_ready_vs_rsp: assert property (
        @(posedge clk) disable iff (!rst_n) !(req_ready && rsp_valid)
    ) else $error("req_ready and rsp_valid high together");

    // sram answers only the access this unit issued
    a_mem_rsp_state: assert property (
        @(posedge clk) disable iff (!rst_n) mem_rsp_valid |-> state == ST_MEM
    ) else $error("mem_rsp_valid outside memory state");

    // held response under back-pressure
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    ) else $error("response changed while waiting for rsp_ready");

endmodule

`default_nettype wire

//--- verilog/data_sram.sv
`default_nettype none

// word-wide synchronous data memory with byte strobes
module data_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req_valid,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t mem_rsp
);

    // word index width, upper address bits wrap
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // drop the byte offset
    assign idx = mem_req.addr[IDX_W+1:2];

    // read old word and write strobed lanes in the same cycle
    always_ff @(posedge clk) begin
        if (mem_req_valid) begin
            mem_rsp.rdata <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (mem_req.we && mem_req.strb[b]) begin
                    mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // response valid trails the request by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= mem_req_valid;
        end
    end

    // every store op from the controller carries a lane
    a_write_strb: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req.we |-> |mem_req.strb
    ) else $error("write with empty strobe at %08h", mem_req.addr);

endmodule

`default_nettype wire

//--- verilog/rv_lsu_top.sv
`default_nettype none

// load/store unit with its data memory
module rv_lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  lsu_op_pkg::lsu_req_t req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output lsu_op_pkg::lsu_rsp_t rsp
);

    // controller to sram
    logic                  mem_req_valid;
    mem_bus_pkg::mem_req_t mem_req;
    logic                  mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t mem_rsp;

    lsu_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    data_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

endmodule

`default_nettype wire

//--- dv/rv_lsu_tb.sv
`default_nettype none

module rv_lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    logic                 req_ready;
    lsu_op_pkg::lsu_req_t req;
    logic                 rsp_valid;
    logic                 rsp_ready;
    lsu_op_pkg::lsu_rsp_t rsp;

    int seed;
    int errors;
    int timeouts;
    int n_req;
    int n_rsp;
    // requests accepted but not yet answered
    int pend_cnt;
    lsu_op_pkg::lsu_req_t pend[$];
    lsu_op_pkg::lsu_rsp_t exp_rsp;
    // byte-wide reference of the first 64 bytes
    logic [7:0] ref_mem [64];
    // rsp_ready pattern, fixed before the clock runs
    logic bp_pat [1024];
    lsu_op_pkg::lsu_op_e ops [8] = '{lsu_op_pkg::LSU_LB, lsu_op_pkg::LSU_LBU,
        lsu_op_pkg::LSU_LH, lsu_op_pkg::LSU_LHU, lsu_op_pkg::LSU_LW,
        lsu_op_pkg::LSU_SB, lsu_op_pkg::LSU_SH, lsu_op_pkg::LSU_SW};

    rv_lsu_top #(
        .MEM_WORDS (256)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // natural alignment, address a multiple of the access size
    function automatic logic misaligned(input lsu_op_pkg::lsu_req_t r);
        int size;
        case (r.op)
            lsu_op_pkg::LSU_LH, lsu_op_pkg::LSU_LHU, lsu_op_pkg::LSU_SH: size = 2;
            lsu_op_pkg::LSU_LW, lsu_op_pkg::LSU_SW: size = 4;
            default: size = 1;
        endcase
        return (r.addr % size) != 0;
    endfunction

    // little-endian byte view of the reference memory
    function automatic lsu_op_pkg::lsu_rsp_t expect_rsp(input lsu_op_pkg::lsu_req_t r);
        lsu_op_pkg::lsu_rsp_t e;
        int          a;
        logic [7:0]  b0;
        logic [15:0] h;
        a       = int'(r.addr[5:0]);
        b0      = ref_mem[a];
        h       = {ref_mem[(a + 1) % 64], ref_mem[a]};
        e.err   = misaligned(r);
        e.ldata = 32'h0;
        if (!e.err) begin
            case (r.op)
                lsu_op_pkg::LSU_LB:  e.ldata = {{24{b0[7]}}, b0};
                lsu_op_pkg::LSU_LBU: e.ldata = {24'h0, b0};
                lsu_op_pkg::LSU_LH:  e.ldata = {{16{h[15]}}, h};
                lsu_op_pkg::LSU_LHU: e.ldata = {16'h0, h};
                lsu_op_pkg::LSU_LW:  e.ldata = {ref_mem[a + 3], ref_mem[a + 2], h};
                // stores answer with zero
                default: e.ldata = 32'h0;
            endcase
        end
        return e;
    endfunction

    // reference write, misaligned stores leave memory alone
    function automatic void apply_store(input lsu_op_pkg::lsu_req_t r);
        int a;
        a = int'(r.addr[5:0]);
        if (!misaligned(r)) begin
            case (r.op)
                lsu_op_pkg::LSU_SB: ref_mem[a] = r.wdata[7:0];
                lsu_op_pkg::LSU_SH: begin
                    ref_mem[a]     = r.wdata[7:0];
                    ref_mem[a + 1] = r.wdata[15:8];
                end
                lsu_op_pkg::LSU_SW: begin
                    for (int i = 0; i < 4; i++) begin
                        ref_mem[a + i] = r.wdata[8*i +: 8];
                    end
                end
                default: ;
            endcase
        end
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts (%0d requests, %0d responses)",
                 errors, timeouts, n_req, n_rsp);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input lsu_op_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req       = '{op: op, addr: addr, wdata: wdata};
        @(posedge clk);
        while (!req_ready && waited < 200) begin
            waited++;
            @(posedge clk);
        end
        if (!req_ready) begin
            timeouts++;
            $display("request handshake stalled for 200 cycles at %0t", $time);
            finish_run();
        end else begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // monitor both channels
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_valid && req_ready) begin
                pend.push_back(req);
                pend_cnt++;
                n_req++;
            end
            if (rsp_valid && rsp_ready) begin
                if (pend.size() != 0) begin
                    apply_store(pend.pop_front());
                    pend_cnt--;
                end
                n_rsp++;
            end
        end
    end

    // expected answer for the oldest request, stable by the next rising edge
    always @(negedge clk) begin
        if (pend.size() != 0) begin
            exp_rsp = expect_rsp(pend[0]);
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> req_ready && !rsp_valid)
        else report_mismatch("unit not idle after reset");

    a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp == exp_rsp)
        else report_mismatch($sformatf("rsp %08h err %0b, expected %08h err %0b",
            $sampled(rsp.ldata), $sampled(rsp.err), exp_rsp.ldata, exp_rsp.err));

    // exactly one response per accepted request
    a_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> pend_cnt == 1)
        else report_mismatch("response without an outstanding request");

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else report_mismatch("response dropped or changed under back-pressure");

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        pend_cnt != 0 |-> !req_ready)
        else report_mismatch("req_ready high with a request in flight");

    // back-pressure on the response side
    initial begin
        int bp_idx;
        bp_idx    = 0;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = bp_pat[bp_idx % 1024];
            bp_idx++;
        end
    end

    initial begin
        int waited;
        seed      = 32'hc6a45018;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < 1024; i++) begin
            bp_pat[i] = |($random(seed) & 3);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // defined contents for every word in range
        for (int w = 0; w < 16; w++) begin
            send_req(lsu_op_pkg::LSU_SW, 32'(w * 4), $random(seed));
        end
        // partial stores, then whole-word readback
        send_req(lsu_op_pkg::LSU_SB, 32'h21, 32'h0000_00a5);
        send_req(lsu_op_pkg::LSU_LW, 32'h20, 32'h0);
        send_req(lsu_op_pkg::LSU_SH, 32'h12, 32'h0000_8c3e);
        send_req(lsu_op_pkg::LSU_LW, 32'h10, 32'h0);
        // bad offsets, memory must stay as it was
        send_req(lsu_op_pkg::LSU_LH, 32'h03, 32'h0);
        send_req(lsu_op_pkg::LSU_LHU, 32'h01, 32'h0);
        send_req(lsu_op_pkg::LSU_SH, 32'h05, 32'hffff_ffff);
        send_req(lsu_op_pkg::LSU_SW, 32'h06, 32'hffff_ffff);
        send_req(lsu_op_pkg::LSU_LW, 32'h02, 32'h0);
        send_req(lsu_op_pkg::LSU_LW, 32'h04, 32'h0);
        for (int n = 0; n < 300; n++) begin
            send_req(ops[$unsigned($random(seed)) % 8], $random(seed) & 32'h3f, $random(seed));
        end
        // drain the last response
        waited = 0;
        while (pend_cnt != 0 && waited < 200) begin
            waited++;
            @(negedge clk);
        end
        if (pend_cnt != 0) begin
            timeouts++;
            $display("last response never arrived within 200 cycles");
        end
        if (n_req != n_rsp) begin
            report_mismatch($sformatf("%0d responses for %0d requests", n_rsp, n_req));
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- rv_lsu.f
verilog/lsu_op_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_load_extract.sv
verilog/lsu_ctrl.sv
verilog/data_sram.sv
verilog/rv_lsu_top.sv
dv/rv_lsu_tb.sv

//--- Bender.yml
package:
  name: rv_lsu

sources:
  - verilog/lsu_op_pkg.sv
  - verilog/mem_bus_pkg.sv
  - verilog/lsu_store_align.sv
  - verilog/lsu_load_extract.sv
  - verilog/lsu_ctrl.sv
  - verilog/data_sram.sv
  - verilog/rv_lsu_top.sv
  - target: test
    files:
      - dv/rv_lsu_tb.sv
